// File: Bender.yml
package:
  name: frame_gen

sources:
  - source/cgmii_pkg.sv
  - source/block_prbs.sv
  - source/frame_fsm.sv
  - source/frame_builder.sv
  - source/frame_gen_top.sv
  - target: test
    files:
      - test/frame_gen_tb.sv

// File: files.f
source/cgmii_pkg.sv
source/block_prbs.sv
source/frame_fsm.sv
source/frame_builder.sv
source/frame_gen_top.sv
test/frame_gen_tb.sv

// File: source/block_prbs.sv
`timescale 1ns/100ps
module block_prbs
	(
	input  logic              i_clock,
	input  logic              i_reset,
	input  logic              i_advance,
	output cgmii_pkg::block_t o_block
	);

	import cgmii_pkg::*;

	logic [NB_BLOCK-1:0] lfsr;
	logic [NB_BLOCK-1:0] lfsr_next;

	// full block worth of shifts, so no bit of the previous word is reused
	function automatic logic [NB_BLOCK-1:0] step_word
		(
		input logic [NB_BLOCK-1:0] seed
		);
		logic [NB_BLOCK-1:0] s;
		logic                fb;
		s  = seed;
		fb = 1'b0;
		for (int i = 0; i < NB_BLOCK; i++)
		begin
			fb = s[63] ^ s[62] ^ s[60] ^ s[59];  // taps 64 63 61 60
			s  = {s[NB_BLOCK-2:0], fb};
		end
		return s;
	endfunction

	assign lfsr_next = step_word(lfsr);

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			lfsr <= LFSR_SEED;
		else if (i_advance)
			lfsr <= lfsr_next;  // new word once the current one is sent
	end

	assign o_block.word = lfsr;

endmodule

// File: source/cgmii_pkg.sv
package cgmii_pkg;

	// block geometry
	localparam int NB_BLOCK = 64;
	localparam int NB_CTRL  = 8;   // one bit per byte lane
	localparam int NB_LANE  = 8;

	// length input widths
	localparam int NB_NDATA = 8;
	localparam int NB_NIDLE = 5;
	localparam int NB_NTERM = 3;

	// cgmii character codes
	localparam logic [NB_LANE-1:0] IDLE_CHAR  = 8'h07;
	localparam logic [NB_LANE-1:0] START_CHAR = 8'hFB;
	localparam logic [NB_LANE-1:0] TERM_CHAR  = 8'hFD;

	// whole blocks
	localparam logic [NB_BLOCK-1:0] SEQ_BLOCK   = 64'h9C68797300000000; // sequence ordered set
	localparam logic [NB_BLOCK-1:0] ERROR_BLOCK = 64'hFEFEFEFEFEFEFEFE;

	// control masks, msb is lane 0
	localparam logic [NB_CTRL-1:0] IDLE_CTRL  = 8'hFF;
	localparam logic [NB_CTRL-1:0] START_CTRL = 8'h80;
	localparam logic [NB_CTRL-1:0] DATA_CTRL  = 8'h00;
	localparam logic [NB_CTRL-1:0] SEQ_CTRL   = 8'h80;

	// terminate mask indexed by the number of trailing data bytes
	localparam logic [NB_CTRL-1:0] term_ctrl_table [NB_CTRL] = '{
		8'hFF,
		8'h7F,
		8'h3F,
		8'h1F,
		8'h0F,
		8'h07,
		8'h03,
		8'h01
	};

	// generator start value, must not be zero
	localparam logic [NB_BLOCK-1:0] LFSR_SEED = 64'hACE1_0F3C_5A96_7E21;

	// frame sequencer states, one-hot
	typedef enum logic [5:0] {
		ST_SEQ   = 6'b000001,
		ST_IDLE  = 6'b000010,
		ST_START = 6'b000100,
		ST_DATA  = 6'b001000,
		ST_TERM  = 6'b010000,
		ST_ERROR = 6'b100000
	} frame_state_t;

	// one 64-bit block seen either as a word or as byte lanes
	typedef union packed {
		logic [NB_BLOCK-1:0]               word;
		logic [0:NB_CTRL-1][NB_LANE-1:0]   lane;  // lane 0 is the top byte
	} block_t;

endpackage

// File: source/frame_builder.sv
`timescale 1ns/100ps
module frame_builder
	(
	input  logic                           i_clock,
	input  logic                           i_reset,
	input  logic                           i_enable,
	input  logic                           i_valid,
	input  logic [cgmii_pkg::NB_NDATA-1:0] i_ndata,
	input  logic [cgmii_pkg::NB_NIDLE-1:0] i_nidle,
	input  logic [cgmii_pkg::NB_NTERM-1:0] i_nterm,
	output cgmii_pkg::block_t              o_tx_data,
	output logic [cgmii_pkg::NB_CTRL-1:0]  o_tx_ctrl,
	output logic                           o_valid
	);

	import cgmii_pkg::*;

	frame_state_t        state;
	logic [NB_NTERM-1:0] term_bytes;
	block_t              gen_block;    // current generator word
	block_t              tx_block;
	logic [NB_CTRL-1:0]  tx_ctrl;
	logic                step;
	logic                advance;

	assign step = i_valid & i_enable & ~i_reset;  // block taken on this edge

	// generator words are used up only by blocks that carry payload
	assign advance = step & ((state == ST_START) | (state == ST_DATA) | (state == ST_TERM));

	always_comb
	begin
		tx_block.word = {NB_CTRL{IDLE_CHAR}};
		tx_ctrl       = IDLE_CTRL;
		case (state)
			ST_SEQ:
			begin
				tx_block.word = SEQ_BLOCK;
				tx_ctrl       = SEQ_CTRL;
			end
			ST_IDLE:
			begin
				tx_block.word = {NB_CTRL{IDLE_CHAR}};
				tx_ctrl       = IDLE_CTRL;
			end
			ST_START:
			begin
				tx_block         = gen_block;
				tx_block.lane[0] = START_CHAR;  // lanes 1 to 7 stay payload
				tx_ctrl          = START_CTRL;
			end
			ST_DATA:
			begin
				tx_block.word = gen_block.word;
				tx_ctrl       = DATA_CTRL;
			end
			ST_TERM:
			begin
				for (int i = 0; i < NB_CTRL; i++)
				begin
					if (i < term_bytes)
						tx_block.lane[i] = gen_block.lane[i];
					else if (i == term_bytes)
						tx_block.lane[i] = TERM_CHAR;
					else
						tx_block.lane[i] = IDLE_CHAR;
				end
				tx_ctrl = term_ctrl_table[term_bytes];
			end
			ST_ERROR:
			begin
				tx_block.word = ERROR_BLOCK;
				tx_ctrl       = IDLE_CTRL;
			end
			default:
			begin
				tx_block.word = ERROR_BLOCK;  // unreachable encoding
				tx_ctrl       = IDLE_CTRL;
			end
		endcase
	end

	assign o_tx_data = tx_block;
	assign o_tx_ctrl = tx_ctrl;
	assign o_valid   = step;

	frame_fsm
	u_frame_fsm
		(
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_step       (step),
		.i_ndata      (i_ndata),
		.i_nidle      (i_nidle),
		.i_nterm      (i_nterm),
		.o_state      (state),
		.o_term_bytes (term_bytes)
		);

	block_prbs
	u_block_prbs
		(
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_advance (advance),
		.o_block   (gen_block)
		);

endmodule

// File: source/frame_fsm.sv
`timescale 1ns/100ps
module frame_fsm
	(
	input  logic                           i_clock,
	input  logic                           i_reset,
	input  logic                           i_step,
	input  logic [cgmii_pkg::NB_NDATA-1:0] i_ndata,
	input  logic [cgmii_pkg::NB_NIDLE-1:0] i_nidle,
	input  logic [cgmii_pkg::NB_NTERM-1:0] i_nterm,
	output cgmii_pkg::frame_state_t        o_state,
	output logic [cgmii_pkg::NB_NTERM-1:0] o_term_bytes
	);

	import cgmii_pkg::*;

	frame_state_t        state;
	frame_state_t        state_next;
	frame_state_t        entry_state;   // first block of the coming frame cycle
	logic [NB_NIDLE-1:0] idle_cnt;      // idles left, current one included
	logic [NB_NDATA-1:0] data_cnt;      // start and data blocks left
	logic [NB_NTERM-1:0] term_bytes;
	logic                at_boundary;

	// lengths are sampled when leaving one of these
	assign at_boundary = (state == ST_SEQ) | (state == ST_TERM) | (state == ST_ERROR);

	always_comb
	begin
		if (i_nidle != '0)
			entry_state = ST_IDLE;
		else if (i_ndata == '0)
			entry_state = ST_ERROR;  // empty frame is not legal
		else
			entry_state = ST_START;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			ST_SEQ, ST_TERM, ST_ERROR:
			begin
				state_next = entry_state;
			end
			ST_IDLE:
			begin
				if (idle_cnt == NB_NIDLE'(1))
				begin
					if (data_cnt == '0)
						state_next = ST_ERROR;
					else
						state_next = ST_START;
				end
			end
			ST_START:
			begin
				// start block already carries data, ndata of one means no data blocks
				if (data_cnt == NB_NDATA'(1))
					state_next = ST_TERM;
				else
					state_next = ST_DATA;
			end
			ST_DATA:
			begin
				if (data_cnt == NB_NDATA'(1))
					state_next = ST_TERM;
			end
			default:
			begin
				state_next = ST_SEQ;
			end
		endcase
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state      <= ST_SEQ;
			idle_cnt   <= '0;
			data_cnt   <= '0;
			term_bytes <= '0;
		end
		else if (i_step)
		begin
			state <= state_next;
			if (at_boundary)
			begin
				idle_cnt   <= i_nidle;
				data_cnt   <= i_ndata;
				term_bytes <= i_nterm;
			end
			else
			begin
				if (state == ST_IDLE)
					idle_cnt <= idle_cnt - 1'b1;
				if ((state == ST_START) | (state == ST_DATA))
					data_cnt <= data_cnt - 1'b1;
			end
		end
	end

	assign o_state      = state;
	assign o_term_bytes = term_bytes;  // held for the whole frame

endmodule

// File: source/frame_gen_top.sv
`timescale 1ns/100ps
module frame_gen_top
	(
	input  logic                           i_clock,
	input  logic                           i_reset,
	input  logic                           i_enable,
	input  logic                           i_valid,
	input  logic [cgmii_pkg::NB_NDATA-1:0] i_ndata,   // start plus data blocks
	input  logic [cgmii_pkg::NB_NIDLE-1:0] i_nidle,
	input  logic [cgmii_pkg::NB_NTERM-1:0] i_nterm,   // trailing bytes in terminate
	output logic [cgmii_pkg::NB_BLOCK-1:0] o_tx_data,
	output logic [cgmii_pkg::NB_CTRL-1:0]  o_tx_ctrl,
	output logic                           o_valid
	);

	frame_builder
	u_frame_builder
		(
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_enable  (i_enable),
		.i_valid   (i_valid),
		.i_ndata   (i_ndata),
		.i_nidle   (i_nidle),
		.i_nterm   (i_nterm),
		.o_tx_data (o_tx_data),
		.o_tx_ctrl (o_tx_ctrl),
		.o_valid   (o_valid)
		);

endmodule

// File: test/frame_gen_tb.sv
`timescale 1ns/100ps
module frame_gen_tb;

	import cgmii_pkg::*;

	localparam int          CLK_PERIOD   = 40;
	localparam int          RESET_CYCLES = 8;
	localparam int          NUM_ROWS     = 14;
	localparam int unsigned SEED         = 32'h819413f2;

	// one row per test with its frame count
	string row_name [NUM_ROWS] = '{
		"basic", "term_0", "term_1", "term_2", "term_3", "term_4", "term_5",
		"term_6", "term_7", "single_start", "empty_frame", "empty_no_idle",
		"back_to_back", "long_frame"
	};
	int row_nidle  [NUM_ROWS] = '{3, 1, 2, 0, 1, 4, 2, 1, 3, 2, 2, 0, 0, 31};
	int row_ndata  [NUM_ROWS] = '{4, 3, 2, 5, 1, 6, 2, 3, 2, 1, 0, 0, 3, 20};
	int row_nterm  [NUM_ROWS] = '{2, 0, 1, 2, 3, 4, 5, 6, 7, 5, 3, 0, 7, 4};
	int row_frames [NUM_ROWS] = '{2, 1, 1, 1, 1, 1, 1, 1, 1, 2, 2, 1, 3, 1};

	logic                i_clock;
	logic                i_reset;
	logic                i_enable;
	logic                i_valid;
	logic [NB_NDATA-1:0] i_ndata;
	logic [NB_NIDLE-1:0] i_nidle;
	logic [NB_NTERM-1:0] i_nterm;
	logic [NB_BLOCK-1:0] o_tx_data;
	logic [NB_CTRL-1:0]  o_tx_ctrl;
	logic                o_valid;
	block_t              tx_block;

	// reference model of the frame sequence
	frame_state_t        m_state;
	logic [NB_BLOCK-1:0] m_lfsr;
	int                  m_idles;
	int                  m_body;   // start plus data blocks still to send
	int                  m_term;

	int          error_count = 0;
	int          check_count = 0;
	int          block_count = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;
	int unsigned seed_value;
	int          frame_row [$];

	frame_gen_top
	DUT
		(
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_enable  (i_enable),
		.i_valid   (i_valid),
		.i_ndata   (i_ndata),
		.i_nidle   (i_nidle),
		.i_nterm   (i_nterm),
		.o_tx_data (o_tx_data),
		.o_tx_ctrl (o_tx_ctrl),
		.o_valid   (o_valid)
		);

	assign tx_block = o_tx_data;

	initial
	begin
		i_clock = 1'b0;
		forever #(CLK_PERIOD/2) i_clock = ~i_clock;
	end

	always @(posedge i_clock)
	begin
		cycle_count <= cycle_count + 1;
		if ((cycle_limit > 0) && (cycle_count >= cycle_limit))
		begin
			$display("timeout: the run did not end within %0d clock cycles", cycle_limit);
			$display("Test failures found");
			$finish;
		end
	end

	// twice the blocks of all frames plus the reset time
	function automatic int timeout_cycles();
		int total;
		total = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			total += row_frames[r] * (row_nidle[r] + row_ndata[r] + 2);
		return 2 * total + RESET_CYCLES;
	endfunction

	// 64 shifts of the x^64+x^63+x^61+x^60 sequence with feedback entering at the lsb
	function automatic logic [NB_BLOCK-1:0] lfsr_next_word(input logic [NB_BLOCK-1:0] cur);
		logic [2*NB_BLOCK-1:0] seq;
		seq = {cur, {NB_BLOCK{1'b0}}};
		for (int i = 0; i < NB_BLOCK; i++)
			seq[63-i] = seq[127-i] ^ seq[126-i] ^ seq[124-i] ^ seq[123-i];
		return seq[NB_BLOCK-1:0];
	endfunction

	function automatic bit at_frame_edge(input frame_state_t st);
		return (st == ST_SEQ) || (st == ST_TERM) || (st == ST_ERROR);
	endfunction

	task automatic predict_block(output block_t blk, output logic [NB_CTRL-1:0] ctrl);
		logic [NB_BLOCK-1:0] w;
		logic [NB_LANE-1:0]  b;
		w    = {NB_CTRL{IDLE_CHAR}};
		ctrl = 8'hFF;
		case (m_state)
			ST_SEQ:
			begin
				w    = SEQ_BLOCK;
				ctrl = 8'h80;
			end
			ST_START:
			begin
				w        = m_lfsr;
				w[63:56] = START_CHAR;  // lane 0 is the top byte
				ctrl     = 8'h80;
			end
			ST_DATA:
			begin
				w    = m_lfsr;
				ctrl = 8'h00;
			end
			ST_TERM:
			begin
				for (int i = 0; i < NB_CTRL; i++)
				begin
					if (i < m_term)
						b = m_lfsr[NB_BLOCK-1-NB_LANE*i -: NB_LANE];
					else if (i == m_term)
						b = TERM_CHAR;
					else
						b = IDLE_CHAR;
					w[NB_BLOCK-1-NB_LANE*i -: NB_LANE] = b;
				end
				ctrl = 8'hFF >> m_term;  // data lanes clear their control bit
			end
			ST_ERROR:
			begin
				w    = {NB_CTRL{8'hFE}};
				ctrl = 8'hFF;
			end
			default:
			begin
				w    = {NB_CTRL{IDLE_CHAR}};
				ctrl = 8'hFF;
			end
		endcase
		blk = w;
	endtask

	// move the model on by one consumed block
	task automatic step_model();
		case (m_state)
			ST_SEQ, ST_TERM, ST_ERROR:
			begin
				if (m_state == ST_TERM)
					m_lfsr = lfsr_next_word(m_lfsr);
				m_idles = i_nidle;
				m_body  = i_ndata;
				m_term  = i_nterm;
				if (m_idles != 0)
					m_state = ST_IDLE;
				else if (m_body == 0)
					m_state = ST_ERROR;
				else
					m_state = ST_START;
			end
			ST_IDLE:
			begin
				m_idles--;
				if (m_idles == 0)
					m_state = (m_body == 0) ? ST_ERROR : ST_START;
			end
			default:
			begin
				m_lfsr = lfsr_next_word(m_lfsr);
				m_body--;
				m_state = (m_body == 0) ? ST_TERM : ST_DATA;
			end
		endcase
	endtask

	task automatic check_block(input string name, input block_t exp, input block_t act);
		check_count++;
		if (act.word !== exp.word)
		begin
			$display("** Error %s: block expected %h, actual %h", name, exp.word, act.word);
			error_count++;
		end
	endtask

	task automatic check_ctrl(input string name, input logic [NB_CTRL-1:0] exp,
		input logic [NB_CTRL-1:0] act);
		check_count++;
		if (act !== exp)
		begin
			$display("** Error %s: ctrl expected %h, actual %h", name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_valid(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp)
		begin
			$display("** Error %s: valid expected %b, actual %b", name, exp, act);
			error_count++;
		end
	endtask

	task automatic apply_lengths(input int r);
		i_nidle = NB_NIDLE'(row_nidle[r]);
		i_ndata = NB_NDATA'(row_ndata[r]);
		i_nterm = NB_NTERM'(row_nterm[r]);
	endtask

	// random stalls first and then the strobe that takes the block
	task automatic send_block(input int r);
		block_t             exp_blk;
		logic [NB_CTRL-1:0] exp_ctrl;
		int                 gaps;
		int                 drop;
		predict_block(exp_blk, exp_ctrl);
		gaps = (($urandom % 4) == 0) ? 1 + int'($urandom % 2) : 0;
		for (int g = 0; g < gaps; g++)
		begin
			drop     = $urandom % 3;
			i_valid  = (drop == 1);
			i_enable = (drop == 0);  // drop 2 lowers both
			#(CLK_PERIOD/4);
			check_valid(row_name[r], 1'b0, o_valid);
			check_block(row_name[r], exp_blk, tx_block);
			check_ctrl(row_name[r], exp_ctrl, o_tx_ctrl);
			@(negedge i_clock);
		end
		i_valid  = 1'b1;
		i_enable = 1'b1;
		#(CLK_PERIOD/4);
		check_valid(row_name[r], 1'b1, o_valid);
		check_block(row_name[r], exp_blk, tx_block);
		check_ctrl(row_name[r], exp_ctrl, o_tx_ctrl);
		@(negedge i_clock);
		i_valid = 1'b0;
		step_model();
		block_count++;
	endtask

	initial
	begin
		int r;
		int next_r;
		int err_start;
		int blk_start;
		seed_value = $urandom(SEED);
		i_reset     = 1'b1;
		i_enable    = 1'b1;
		i_valid     = 1'b1;  // strobe held high so reset alone must keep o_valid low
		i_ndata     = '0;
		i_nidle     = '0;
		i_nterm     = '0;
		m_state     = ST_SEQ;
		m_lfsr      = LFSR_SEED;
		m_idles     = 0;
		m_body      = 0;
		m_term      = 0;
		cycle_limit = timeout_cycles();

		repeat (RESET_CYCLES)
		begin
			@(negedge i_clock);
			check_valid("reset", 1'b0, o_valid);
		end
		i_reset = 1'b0;
		i_valid = 1'b0;

		for (int k = 0; k < NUM_ROWS; k++)
			for (int f = 0; f < row_frames[k]; f++)
				frame_row.push_back(k);

		err_start = error_count;
		blk_start = block_count;
		apply_lengths(frame_row[0]);
		send_block(frame_row[0]);  // ordered set
		for (int k = 0; k < frame_row.size(); k++)
		begin
			r = frame_row[k];
			while (!at_frame_edge(m_state))
				send_block(r);
			// next lengths must be present when the terminate or error block goes
			next_r = (k + 1 < frame_row.size()) ? frame_row[k+1] : r;
			apply_lengths(next_r);
			send_block(r);
			if ((next_r != r) || (k + 1 == frame_row.size()))
			begin
				$display("%-14s frames %0d  blocks %0d  errors %0d", row_name[r],
					row_frames[r], block_count - blk_start, error_count - err_start);
				err_start = error_count;
				blk_start = block_count;
			end
		end

		$display("summary: %0d rows, %0d blocks, %0d checks, %0d errors",
			NUM_ROWS, block_count, check_count, error_count);
		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
